//--- logic/iob_bus_pkg.sv
package iob_bus_pkg;

  // Byte address width on both AXI4-Lite and IOb
  localparam int ADDR_W = 12;

  // Data path is one 32-bit word
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // Word RAM covers the full byte address space
  localparam int MEM_WORDS = 1024;

  // Buffer depths between bridge and RAM
  localparam int REQ_DEPTH = 4;
  localparam int RSP_DEPTH = 4;

  // One IOb request where an all-zero wstrb marks a read
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } iob_req_t;

  // One read response
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
  } iob_rsp_t;

endpackage

//--- logic/axil2iob.sv
`timescale 1ns/1ps

module axil2iob (
  input  logic                             clk_i,
  input  logic                             reset_i,

  // AXI4-Lite write address and write data
  input  logic                             axil_awvalid_i,
  input  logic [iob_bus_pkg::ADDR_W-1:0]   axil_awaddr_i,
  output logic                             axil_awready_o,
  input  logic                             axil_wvalid_i,
  input  logic [iob_bus_pkg::DATA_W-1:0]   axil_wdata_i,
  input  logic [iob_bus_pkg::STRB_W-1:0]   axil_wstrb_i,
  output logic                             axil_wready_o,

  // AXI4-Lite write response
  output logic                             axil_bvalid_o,
  input  logic                             axil_bready_i,
  output logic [1:0]                       axil_bresp_o,

  // AXI4-Lite read address and read data
  input  logic                             axil_arvalid_i,
  input  logic [iob_bus_pkg::ADDR_W-1:0]   axil_araddr_i,
  output logic                             axil_arready_o,
  output logic                             axil_rvalid_o,
  input  logic                             axil_rready_i,
  output logic [iob_bus_pkg::DATA_W-1:0]   axil_rdata_o,
  output logic [1:0]                       axil_rresp_o,

  // IOb request toward the request FIFO
  output iob_bus_pkg::iob_req_t            iob_req_o,
  output logic                             iob_req_valid_o,
  input  logic                             iob_req_ready_i,

  // Read responses from the response FIFO
  input  iob_bus_pkg::iob_rsp_t            iob_rsp_i,
  input  logic                             iob_rsp_valid_i,
  output logic                             iob_rsp_ready_o
);

  import iob_bus_pkg::*;

  logic     bvalid_q;
  logic     b_stall;
  logic     rd_sel;
  logic     wr_pair;
  logic     wr_has_strb;
  logic     wr_ready;
  logic     wr_fire;
  iob_req_t req;

  // Response still waiting for the master
  assign b_stall = bvalid_q & ~axil_bready_i;

  // A pending read always wins the request slot
  assign rd_sel = axil_arvalid_i;

  // Address and data are taken together only
  assign wr_pair     = axil_awvalid_i & axil_wvalid_i;
  assign wr_has_strb = |axil_wstrb_i;

  assign wr_ready = iob_req_ready_i & ~b_stall & ~rd_sel;
  assign wr_fire  = wr_pair & wr_ready;

  assign axil_arready_o = iob_req_ready_i;
  assign axil_awready_o = wr_ready;
  assign axil_wready_o  = wr_ready;

  // Zero-strobe writes get a response but never reach the RAM
  assign iob_req_valid_o = rd_sel | (wr_pair & wr_has_strb & ~b_stall);

  always_comb begin
    if (rd_sel) begin
      req.addr  = axil_araddr_i;
      req.wdata = '0;
      req.wstrb = '0;
    end else begin
      req.addr  = axil_awaddr_i;
      req.wdata = axil_wdata_i;
      req.wstrb = axil_wstrb_i;
    end
  end

  assign iob_req_o = req;

  // Write response set on acceptance and held until taken
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bvalid_q <= 1'b0;
    end else if (wr_fire) begin
      bvalid_q <= 1'b1;
    end else if (axil_bready_i) begin
      bvalid_q <= 1'b0;
    end
  end

  assign axil_bvalid_o = bvalid_q;
  assign axil_bresp_o  = 2'b00;

  // Read data comes back in order through the response FIFO
  assign axil_rvalid_o   = iob_rsp_valid_i;
  assign axil_rdata_o    = iob_rsp_i.rdata;
  assign iob_rsp_ready_o = axil_rready_i;
  // OKAY
  assign axil_rresp_o    = 2'b00;

endmodule

//--- logic/iob_fifo.sv
`timescale 1ns/1ps

module iob_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk_i,
  input  logic     reset_i,

  // Push side
  input  logic     push_valid_i,
  output logic     push_ready_o,
  input  payload_t push_data_i,

  // Pop side
  output logic     pop_valid_o,
  input  logic     pop_ready_i,
  output payload_t pop_data_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push_fire;
  logic             pop_fire;

  // Pointer advance with wrap at DEPTH
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push_ready_o = (count_q != CNT_W'(DEPTH));
  assign pop_valid_o  = (count_q != '0);

  assign push_fire = push_valid_i & push_ready_o;
  assign pop_fire  = pop_valid_o & pop_ready_i;

  // Head entry is always on the pop side
  assign pop_data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_fire) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_fire) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // Occupancy tracks push and pop together
      case ({push_fire, pop_fire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

//--- logic/iob_ram.sv
`timescale 1ns/1ps

module iob_ram (
  input  logic                  clk_i,
  input  logic                  reset_i,

  // Requests from the request FIFO
  input  iob_bus_pkg::iob_req_t req_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,

  // Read responses toward the response FIFO
  output iob_bus_pkg::iob_rsp_t rsp_o,
  output logic                  rsp_valid_o,
  input  logic                  rsp_ready_i
);

  import iob_bus_pkg::*;

  logic [DATA_W-1:0] mem_q [MEM_WORDS];
  logic [ADDR_W-3:0] word_addr;
  logic              is_read;
  logic              pop_fire;
  logic              rd_fire;
  logic              wr_fire;
  iob_rsp_t          rsp_q;
  logic              rsp_valid_q;

  // Byte address down to word index
  assign word_addr = req_i.addr[ADDR_W-1:2];
  assign is_read   = (req_i.wstrb == '0);

  // Only a read waiting behind an undelivered response stalls
  assign req_ready_o = ~(rsp_valid_q & req_valid_i & is_read);

  assign pop_fire = req_valid_i & req_ready_o;
  assign rd_fire  = pop_fire & is_read;
  assign wr_fire  = pop_fire & ~is_read;

  // Byte-strobed write
  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (req_i.wstrb[b]) begin
          mem_q[word_addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Read word held until the response is taken
  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      rsp_q.rdata <= mem_q[word_addr];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q <= 1'b0;
    end else if (rd_fire) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  assign rsp_o       = rsp_q;
  assign rsp_valid_o = rsp_valid_q;

endmodule

//--- logic/axil_iob_top.sv
`timescale 1ns/1ps

module axil_iob_top (
  input  logic                             clk_i,
  input  logic                             reset_i,

  // AXI4-Lite write channels
  input  logic                             axil_awvalid_i,
  input  logic [iob_bus_pkg::ADDR_W-1:0]   axil_awaddr_i,
  output logic                             axil_awready_o,
  input  logic                             axil_wvalid_i,
  input  logic [iob_bus_pkg::DATA_W-1:0]   axil_wdata_i,
  input  logic [iob_bus_pkg::STRB_W-1:0]   axil_wstrb_i,
  output logic                             axil_wready_o,
  output logic                             axil_bvalid_o,
  input  logic                             axil_bready_i,
  output logic [1:0]                       axil_bresp_o,

  // AXI4-Lite read channels
  input  logic                             axil_arvalid_i,
  input  logic [iob_bus_pkg::ADDR_W-1:0]   axil_araddr_i,
  output logic                             axil_arready_o,
  output logic                             axil_rvalid_o,
  input  logic                             axil_rready_i,
  output logic [iob_bus_pkg::DATA_W-1:0]   axil_rdata_o,
  output logic [1:0]                       axil_rresp_o
);

  import iob_bus_pkg::*;

  // Bridge to request FIFO
  iob_req_t bridge_req;
  logic     bridge_req_valid;
  logic     bridge_req_ready;

  // Request FIFO to RAM
  iob_req_t ram_req;
  logic     ram_req_valid;
  logic     ram_req_ready;

  // RAM to response FIFO
  iob_rsp_t ram_rsp;
  logic     ram_rsp_valid;
  logic     ram_rsp_ready;

  // Response FIFO back to bridge
  iob_rsp_t bridge_rsp;
  logic     bridge_rsp_valid;
  logic     bridge_rsp_ready;

  axil2iob u_bridge (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .axil_awvalid_i  (axil_awvalid_i),
    .axil_awaddr_i   (axil_awaddr_i),
    .axil_awready_o  (axil_awready_o),
    .axil_wvalid_i   (axil_wvalid_i),
    .axil_wdata_i    (axil_wdata_i),
    .axil_wstrb_i    (axil_wstrb_i),
    .axil_wready_o   (axil_wready_o),
    .axil_bvalid_o   (axil_bvalid_o),
    .axil_bready_i   (axil_bready_i),
    .axil_bresp_o    (axil_bresp_o),
    .axil_arvalid_i  (axil_arvalid_i),
    .axil_araddr_i   (axil_araddr_i),
    .axil_arready_o  (axil_arready_o),
    .axil_rvalid_o   (axil_rvalid_o),
    .axil_rready_i   (axil_rready_i),
    .axil_rdata_o    (axil_rdata_o),
    .axil_rresp_o    (axil_rresp_o),
    .iob_req_o       (bridge_req),
    .iob_req_valid_o (bridge_req_valid),
    .iob_req_ready_i (bridge_req_ready),
    .iob_rsp_i       (bridge_rsp),
    .iob_rsp_valid_i (bridge_rsp_valid),
    .iob_rsp_ready_o (bridge_rsp_ready)
  );

  iob_fifo #(
    .payload_t (iob_req_t),
    .DEPTH     (REQ_DEPTH)
  ) u_req_fifo (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .push_valid_i (bridge_req_valid),
    .push_ready_o (bridge_req_ready),
    .push_data_i  (bridge_req),
    .pop_valid_o  (ram_req_valid),
    .pop_ready_i  (ram_req_ready),
    .pop_data_o   (ram_req)
  );

  iob_ram u_ram (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_i       (ram_req),
    .req_valid_i (ram_req_valid),
    .req_ready_o (ram_req_ready),
    .rsp_o       (ram_rsp),
    .rsp_valid_o (ram_rsp_valid),
    .rsp_ready_i (ram_rsp_ready)
  );

  iob_fifo #(
    .payload_t (iob_rsp_t),
    .DEPTH     (RSP_DEPTH)
  ) u_rsp_fifo (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .push_valid_i (ram_rsp_valid),
    .push_ready_o (ram_rsp_ready),
    .push_data_i  (ram_rsp),
    .pop_valid_o  (bridge_rsp_valid),
    .pop_ready_i  (bridge_rsp_ready),
    .pop_data_o   (bridge_rsp)
  );

endmodule

//--- dv/axil_iob_tb.sv
`timescale 1ns/1ps

module axil_iob_tb;

  import iob_bus_pkg::*;

  localparam int NUM_VEC  = 41;
  localparam int VEC_COLS = 5;
  localparam int TIMEOUT  = 200;

  logic              clk_i;
  logic              reset_i;
  logic              axil_awvalid_i;
  logic [ADDR_W-1:0] axil_awaddr_i;
  logic              axil_awready_o;
  logic              axil_wvalid_i;
  logic [DATA_W-1:0] axil_wdata_i;
  logic [STRB_W-1:0] axil_wstrb_i;
  logic              axil_wready_o;
  logic              axil_bvalid_o;
  logic              axil_bready_i;
  logic [1:0]        axil_bresp_o;
  logic              axil_arvalid_i;
  logic [ADDR_W-1:0] axil_araddr_i;
  logic              axil_arready_o;
  logic              axil_rvalid_o;
  logic              axil_rready_i;
  logic [DATA_W-1:0] axil_rdata_o;
  logic [1:0]        axil_rresp_o;

  logic [31:0] vec_mem [0:NUM_VEC*VEC_COLS-1];
  logic [31:0] exp_q [$];
  int          acc_q [$];
  logic [31:0] exp_word;
  int          acc_cycle;
  int          cycle = 0;
  int          errors = 0;
  int          timeouts = 0;
  int          reads_issued = 0;
  int          reads_done = 0;
  integer      seed = 27;

  axil_iob_top UUT (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .axil_awvalid_i (axil_awvalid_i),
    .axil_awaddr_i  (axil_awaddr_i),
    .axil_awready_o (axil_awready_o),
    .axil_wvalid_i  (axil_wvalid_i),
    .axil_wdata_i   (axil_wdata_i),
    .axil_wstrb_i   (axil_wstrb_i),
    .axil_wready_o  (axil_wready_o),
    .axil_bvalid_o  (axil_bvalid_o),
    .axil_bready_i  (axil_bready_i),
    .axil_bresp_o   (axil_bresp_o),
    .axil_arvalid_i (axil_arvalid_i),
    .axil_araddr_i  (axil_araddr_i),
    .axil_arready_o (axil_arready_o),
    .axil_rvalid_o  (axil_rvalid_o),
    .axil_rready_i  (axil_rready_i),
    .axil_rdata_o   (axil_rdata_o),
    .axil_rresp_o   (axil_rresp_o)
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) cycle <= cycle + 1;

  // Random back-pressure on both response channels
  always @(posedge clk_i) begin
    #1;
    axil_bready_i = ($random(seed) & 3) != 0;
    axil_rready_i = ($random(seed) & 1) != 0;
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("ERR %s expected 0x%h got 0x%h", name, exp, act);
    errors++;
  endtask

  task automatic note_timeout(input string chan);
    $display("Timeout after %0d cycles waiting on the %s channel", TIMEOUT, chan);
    timeouts++;
  endtask

  // Read data is checked in issue order
  always @(posedge clk_i) begin
    if (!reset_i && axil_rvalid_o && axil_rready_i) begin
      if (exp_q.size() == 0) begin
        $display("Read data arrived while no read was outstanding");
        errors++;
      end else begin
        exp_word  = exp_q.pop_front();
        acc_cycle = acc_q.pop_front();
        reads_done++;
        if (axil_rdata_o !== exp_word) begin
          report_mismatch("axil_rdata_o", exp_word, axil_rdata_o);
        end
        if (axil_rresp_o !== 2'b00) begin
          report_mismatch("axil_rresp_o", 32'h0, {30'h0, axil_rresp_o});
        end
        if (cycle - acc_cycle < 3) begin
          $display("Read data returned %0d cycles after acceptance, below three",
                   cycle - acc_cycle);
          errors++;
        end
      end
    end
  end

  task automatic drain_reads();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < TIMEOUT) begin
      @(posedge clk_i);
      n++;
    end
    #1;
    if (exp_q.size() != 0) begin
      note_timeout("read data");
    end
  endtask

  task automatic write_vec(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [STRB_W-1:0] strb);
    int   n;
    logic done;
    axil_awvalid_i = 1'b1;
    axil_wvalid_i  = 1'b1;
    axil_awaddr_i  = addr;
    axil_wdata_i   = data;
    axil_wstrb_i   = strb;
    n    = 0;
    done = 1'b0;
    while (!done && n < TIMEOUT) begin
      @(posedge clk_i);
      n++;
      if (axil_awready_o !== axil_wready_o) begin
        report_mismatch("axil_wready_o", {31'h0, axil_awready_o}, {31'h0, axil_wready_o});
      end
      if (axil_awready_o && axil_wready_o) begin
        done = 1'b1;
      end
    end
    #1;
    axil_awvalid_i = 1'b0;
    axil_wvalid_i  = 1'b0;
    if (!done) begin
      note_timeout("write address and data");
    end else begin
      // Response due exactly one cycle after acceptance
      @(posedge clk_i);
      if (axil_bvalid_o !== 1'b1) begin
        report_mismatch("axil_bvalid_o", 32'h1, {31'h0, axil_bvalid_o});
      end
      if (axil_bresp_o !== 2'b00) begin
        report_mismatch("axil_bresp_o", 32'h0, {30'h0, axil_bresp_o});
      end
      n = 0;
      while (!(axil_bvalid_o && axil_bready_i) && n < TIMEOUT) begin
        @(posedge clk_i);
        n++;
      end
      if (!(axil_bvalid_o && axil_bready_i)) begin
        note_timeout("write response");
      end
      #1;
    end
  endtask

  task automatic read_vec(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp,
                          input bit drain);
    int   n;
    logic done;
    axil_arvalid_i = 1'b1;
    axil_araddr_i  = addr;
    n    = 0;
    done = 1'b0;
    while (!done && n < TIMEOUT) begin
      @(posedge clk_i);
      n++;
      if (axil_arready_o) begin
        done = 1'b1;
        exp_q.push_back(exp);
        acc_q.push_back(cycle);
        reads_issued++;
      end
    end
    #1;
    axil_arvalid_i = 1'b0;
    if (!done) begin
      note_timeout("read address");
    end else if (drain) begin
      drain_reads();
    end
  endtask

  task automatic run_vectors();
    logic [31:0] op;
    for (int v = 0; v < NUM_VEC && timeouts == 0; v++) begin
      op = vec_mem[v*VEC_COLS];
      case (op)
        32'h1: write_vec(vec_mem[v*VEC_COLS+1][ADDR_W-1:0], vec_mem[v*VEC_COLS+2],
                         vec_mem[v*VEC_COLS+3][STRB_W-1:0]);
        32'h2: read_vec(vec_mem[v*VEC_COLS+1][ADDR_W-1:0], vec_mem[v*VEC_COLS+4], 1'b1);
        32'h3: read_vec(vec_mem[v*VEC_COLS+1][ADDR_W-1:0], vec_mem[v*VEC_COLS+4], 1'b0);
        default: begin
          $display("Vector %0d holds an unknown operation code %h", v, op);
          errors++;
        end
      endcase
    end
  endtask

  initial begin
    int n;
    clk_i          = 1'b0;
    reset_i        = 1'b1;
    axil_awvalid_i = 1'b0;
    axil_awaddr_i  = '0;
    axil_wvalid_i  = 1'b0;
    axil_wdata_i   = '0;
    axil_wstrb_i   = '0;
    axil_bready_i  = 1'b0;
    axil_arvalid_i = 1'b0;
    axil_araddr_i  = '0;
    axil_rready_i  = 1'b0;
    $readmemh("dv/axil_iob_vectors.txt", vec_mem);

    repeat (16) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    @(posedge clk_i);
    if (axil_bvalid_o !== 1'b0) begin
      report_mismatch("axil_bvalid_o", 32'h0, {31'h0, axil_bvalid_o});
    end
    if (axil_rvalid_o !== 1'b0) begin
      report_mismatch("axil_rvalid_o", 32'h0, {31'h0, axil_rvalid_o});
    end
    n = 0;
    while (!(axil_awready_o === 1'b1 && axil_arready_o === 1'b1) && n < TIMEOUT) begin
      @(posedge clk_i);
      n++;
    end
    #1;
    if (!(axil_awready_o === 1'b1 && axil_arready_o === 1'b1)) begin
      note_timeout("ready after reset");
    end

    if ($isunknown(vec_mem[0])) begin
      $display("The vectors file did not load");
      errors++;
    end else if (timeouts == 0) begin
      run_vectors();
      if (timeouts == 0) begin
        drain_reads();
      end
    end

    if (timeouts == 0 && reads_done != reads_issued) begin
      $display("Issued %0d reads but received %0d responses", reads_issued, reads_done);
      errors++;
    end

    $display("Run finished with %0d errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
logic/iob_bus_pkg.sv
logic/axil2iob.sv
logic/iob_fifo.sv
logic/iob_ram.sv
logic/axil_iob_top.sv
dv/axil_iob_tb.sv

//--- dv/axil_iob_vectors.txt
// Columns: op addr wdata strb expected_rdata, all hex
// op 1 write, op 2 read then wait for all reads, op 3 read without waiting
1 010 deadbeef f 00000000
2 010 00000000 0 deadbeef
1 020 11223344 f 00000000
1 020 aabbccdd 1 00000000
1 020 55667788 6 00000000
1 020 99000000 8 00000000
2 020 00000000 0 996677dd
1 024 0000beef 3 00000000
1 024 cafe0000 c 00000000
2 024 00000000 0 cafebeef
1 010 12345678 0 00000000
2 010 00000000 0 deadbeef
1 100 c0de0100 f 00000000
1 104 c0de0104 f 00000000
1 108 c0de0108 f 00000000
1 10c c0de010c f 00000000
1 110 c0de0110 f 00000000
1 114 c0de0114 f 00000000
1 118 c0de0118 f 00000000
1 11c c0de011c f 00000000
1 120 c0de0120 f 00000000
1 124 c0de0124 f 00000000
1 128 c0de0128 f 00000000
1 12c c0de012c f 00000000
3 100 00000000 0 c0de0100
3 104 00000000 0 c0de0104
3 108 00000000 0 c0de0108
3 10c 00000000 0 c0de010c
3 110 00000000 0 c0de0110
3 114 00000000 0 c0de0114
3 118 00000000 0 c0de0118
3 11c 00000000 0 c0de011c
3 120 00000000 0 c0de0120
3 124 00000000 0 c0de0124
3 128 00000000 0 c0de0128
3 12c 00000000 0 c0de012c
1 200 0badf00d f 00000000
3 200 00000000 0 0badf00d
1 200 00001234 3 00000000
3 200 00000000 0 0bad1234
2 104 00000000 0 c0de0104
